//--- source/qr_finder_pkg.sv
package qr_finder_pkg;

  // stored window, a square cut from the left of the 640x480 camera frame
  localparam int stored_width = 480;  // columns kept per row
  localparam int stored_height = 480; // rows kept per frame
  localparam int pixel_count = stored_width * stored_height; // one bit per kept pixel

  // buffer address, col + 480*row, tops out at 230399
  localparam int addr_w = 18;

  // camera coordinate widths as they come out of pixel recovery
  localparam int hcount_w = 11;
  localparam int vcount_w = 10;

  localparam int pixel_w = 16;  // 565 rgb
  localparam int thresh_w = 8;  // threshold and luminance share a scale

  // run length must hold a run that spans a whole row
  localparam int run_w = 9;

  // scanner walk counters
  localparam int col_w = 9;
  localparam int row_w = 9;

  // address in to bit out on the frame buffer read port
  localparam int read_latency = 2;

  // scan phase
  typedef enum logic [1:0] {
    streaming, // camera writes into the buffer
    scanning,  // buffer frozen, rows walked through the checker
    finished   // row flags stable until the next start
  } scan_state_t;

endpackage

//--- source/pixel_binarizer.sv
`timescale 1ns/10ps

module pixel_binarizer (
  input  logic                              clk_pixel,
  input  logic                              sys_rst,
  input  logic [qr_finder_pkg::pixel_w-1:0]  pixel,
  input  logic [qr_finder_pkg::hcount_w-1:0] hcount,
  input  logic [qr_finder_pkg::vcount_w-1:0] vcount,
  input  logic                              pixel_valid,
  input  logic [qr_finder_pkg::thresh_w-1:0] thresh,
  input  logic                              capture_en,
  output logic                              wr_en,
  output logic [qr_finder_pkg::addr_w-1:0]   wr_addr,
  output logic                              wr_bit
);
  import qr_finder_pkg::*;

  logic [thresh_w-1:0] luma;     // green only, scaled up to 8 bits
  logic                white;    // 1 = white, 0 = black
  logic                in_window;
  logic [addr_w-1:0]   pix_addr;

  always_comb begin
    // g field is pixel[10:5], times four puts it on the 0..252 scale
    luma = {pixel[10:5], 2'b00};
    white = luma >= thresh; // at threshold counts as white

    // only the 480x480 corner is kept, the rest of the 640 wide line is dropped
    in_window = (hcount < hcount_w'(stored_width)) &&
                (vcount < vcount_w'(stored_height));

    // row major, one row is stored_width entries
    pix_addr = addr_w'(hcount) + addr_w'(vcount) * addr_w'(stored_width);
  end

  // write strobe, one cycle after the pixel strobe
  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      wr_en <= 1'b0;
    end else begin
      wr_en <= pixel_valid && capture_en && in_window; // frozen buffer drops pixels
    end
  end

  // address and data ride along with the strobe
  always_ff @(posedge clk_pixel) begin
    if (pixel_valid) begin
      wr_addr <= pix_addr;
      wr_bit <= white;
    end
  end

endmodule

//--- source/bit_frame_buffer.sv
`timescale 1ns/10ps

module bit_frame_buffer (
  input  logic                            clk_pixel,
  input  logic                            wr_en,
  input  logic [qr_finder_pkg::addr_w-1:0] wr_addr,
  input  logic                            wr_bit,
  input  logic                            rd_en,
  input  logic [qr_finder_pkg::addr_w-1:0] rd_addr,
  output logic                            rd_bit
);
  import qr_finder_pkg::*;

  // one bit per stored pixel, should map onto block ram
  logic mem [pixel_count];

  logic rd_q; // first read stage, array output latch

  // write port, camera side
  always_ff @(posedge clk_pixel) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_bit;
    end
  end

  // read port, scanner side
  // nonblocking read sees the old bit on a same address write
  always_ff @(posedge clk_pixel) begin
    if (rd_en) begin
      rd_q <= mem[rd_addr];
    end
    rd_bit <= rd_q; // output register, second cycle of latency
  end

endmodule

//--- source/run_ratio_checker.sv
`timescale 1ns/10ps

module run_ratio_checker (
  input  logic clk_pixel,
  input  logic sys_rst,
  input  logic pix_valid,
  input  logic pix_bit,   // 1 = white
  input  logic row_last,  // last pixel of the row
  output logic row_hit,   // row held a 1:1:3:1:1 mark
  output logic row_end    // strobe one cycle after row_last
);
  import qr_finder_pkg::*;

  logic [run_w-1:0] cur_len;  // open run length or zero before the first pixel
  logic             cur_color;
  logic [run_w-1:0] hist [4]; // closed runs with hist[3] newest
  logic [2:0]       cnt;      // closed runs in hist up to 4
  logic             hit_acc;  // a hit seen earlier in this row

  logic             first;
  logic             chg;
  logic [run_w-1:0] len1;     // length of the run closed by this pixel
  logic             close1;
  logic             close2;
  logic             hit1;
  logic             hit2;

  // outer run x fits when 2*|4x - s| <= s for outer sum s
  function automatic logic outer_ok(input int x, input int s);
    int diff;
    diff = 4 * x - s;
    if (diff < 0) begin
      diff = -diff;
    end
    return (2 * diff) <= s;
  endfunction

  // a b c d e oldest first with c the centre run
  function automatic logic ratio_ok(input logic [run_w-1:0] a, b, c, d, e);
    int s;
    int cc;
    s = int'(a) + int'(b) + int'(d) + int'(e);
    cc = int'(c);
    return outer_ok(int'(a), s) && outer_ok(int'(b), s) &&
           outer_ok(int'(d), s) && outer_ok(int'(e), s) &&
           (s <= 2 * cc) && (cc <= s); // centre roughly three units
  endfunction

  always_comb begin
    first = cur_len == '0;
    chg = !first && (pix_bit != cur_color);
    // a colour change closes the old run and the row end closes it with this pixel
    len1 = chg ? cur_len : cur_len + 1'b1;
    close1 = pix_valid && !first && (chg || row_last);
    // change on the last pixel also closes a one pixel run right away
    close2 = pix_valid && row_last && chg;

    // colours alternate so the window starts with the closing run's colour
    hit1 = close1 && (cnt == 3'd4) && !cur_color &&
           ratio_ok(hist[0], hist[1], hist[2], hist[3], len1);
    hit2 = close2 && (cnt >= 3'd3) && !pix_bit &&
           ratio_ok(hist[1], hist[2], hist[3], cur_len, run_w'(1));
  end

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      cur_len <= '0;
      cnt <= '0;
      hit_acc <= 1'b0;
      row_hit <= 1'b0;
      row_end <= 1'b0;
    end else begin
      row_end <= pix_valid && row_last;
      row_hit <= pix_valid && row_last && (hit_acc || hit1 || hit2);
      if (pix_valid) begin
        if (row_last) begin
          // history never crosses a row
          cur_len <= '0;
          cnt <= '0;
          hit_acc <= 1'b0;
        end else begin
          hit_acc <= hit_acc || hit1;
          cur_len <= (first || chg) ? run_w'(1) : cur_len + 1'b1;
          if (chg && (cnt != 3'd4)) begin
            cnt <= cnt + 1'b1;
          end
        end
      end
    end
  end

  // run colour and closed run lengths
  always_ff @(posedge clk_pixel) begin
    if (pix_valid && (first || chg)) begin
      cur_color <= pix_bit;
    end
    if (pix_valid && chg) begin
      hist[0] <= hist[1]; // oldest falls out
      hist[1] <= hist[2];
      hist[2] <= hist[3];
      hist[3] <= cur_len;
    end
  end

endmodule

//--- source/finder_scanner.sv
`timescale 1ns/10ps

module finder_scanner (
  input  logic                                   clk_pixel,
  input  logic                                   sys_rst,
  input  logic                                   start,
  output logic                                   capture_en,
  output logic                                   rd_en,
  output logic [qr_finder_pkg::addr_w-1:0]        rd_addr,
  input  logic                                   rd_bit,
  output logic [qr_finder_pkg::stored_height-1:0] row_flags,
  output logic                                   done
);
  import qr_finder_pkg::*;

  scan_state_t             state;
  logic [col_w-1:0]        col;       // column of the address in rd_addr
  logic [row_w-1:0]        row;
  logic [row_w-1:0]        out_row;   // row whose result arrives next
  logic                    col_last;
  logic                    addr_last;
  logic [read_latency-1:0] vld_dly;   // rd_en delayed to line up with rd_bit
  logic [read_latency-1:0] last_dly;
  logic                    pix_valid;
  logic                    row_last;
  logic                    row_hit;
  logic                    row_end;

  assign col_last = col == col_w'(stored_width - 1);
  assign addr_last = col_last && (row == row_w'(stored_height - 1));
  assign capture_en = state == streaming; // camera may write only here

  // phase, done and result collection
  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      state <= streaming;
      done <= 1'b0;
      out_row <= '0;
      row_flags <= '0;
    end else begin
      done <= 1'b0;
      case (state)
        streaming: begin
          if (start) begin
            state <= scanning;
            out_row <= '0;
          end
        end
        scanning: begin // start is ignored here
          if (row_end) begin
            row_flags[out_row] <= row_hit;
            out_row <= out_row + 1'b1;
            if (out_row == row_w'(stored_height - 1)) begin
              state <= finished;
              done <= 1'b1;
            end
          end
        end
        finished: if (start) state <= streaming;
        default: state <= streaming;
      endcase
    end
  end

  // address walk, one read per cycle in row major order
  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      rd_en <= 1'b0;
      rd_addr <= '0;
      col <= '0;
      row <= '0;
    end else if ((state == streaming) && start) begin
      rd_en <= 1'b1;
      rd_addr <= '0;
      col <= '0;
      row <= '0;
    end else if (rd_en) begin
      rd_en <= !addr_last; // stop after pixel_count reads
      rd_addr <= rd_addr + 1'b1;
      if (col_last) begin
        col <= '0;
        row <= row + 1'b1;
      end else begin
        col <= col + 1'b1;
      end
    end
  end

  // markers follow the data through the buffer pipeline
  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      vld_dly <= '0;
      last_dly <= '0;
    end else begin
      vld_dly <= {vld_dly[read_latency-2:0], rd_en};
      last_dly <= {last_dly[read_latency-2:0], rd_en && col_last};
    end
  end

  assign pix_valid = vld_dly[read_latency-1];
  assign row_last = last_dly[read_latency-1];

  run_ratio_checker i_run_ratio_checker (
    .clk_pixel (clk_pixel),
    .sys_rst   (sys_rst),
    .pix_valid (pix_valid),
    .pix_bit   (rd_bit),
    .row_last  (row_last),
    .row_hit   (row_hit),
    .row_end   (row_end)
  );

endmodule

//--- source/qr_finder_top.sv
`timescale 1ns/10ps

module qr_finder_top (
  input  logic                                   clk_pixel,
  input  logic                                   sys_rst,
  input  logic [qr_finder_pkg::pixel_w-1:0]       pixel,
  input  logic [qr_finder_pkg::hcount_w-1:0]      hcount,
  input  logic [qr_finder_pkg::vcount_w-1:0]      vcount,
  input  logic                                   pixel_valid,
  input  logic [qr_finder_pkg::thresh_w-1:0]      thresh,
  input  logic                                   start,
  output logic                                   streaming,  // buffer takes camera pixels
  output logic [qr_finder_pkg::stored_height-1:0] row_flags,  // one bit per stored row
  output logic                                   done
);
  import qr_finder_pkg::*;

  // camera side write port
  logic              wr_en;
  logic [addr_w-1:0] wr_addr;
  logic              wr_bit;

  // scanner side read port
  logic              rd_en;
  logic [addr_w-1:0] rd_addr;
  logic              rd_bit;

  // producer, pixel stream to buffer writes
  pixel_binarizer i_pixel_binarizer (
    .clk_pixel   (clk_pixel),
    .sys_rst     (sys_rst),
    .pixel       (pixel),
    .hcount      (hcount),
    .vcount      (vcount),
    .pixel_valid (pixel_valid),
    .thresh      (thresh),
    .capture_en  (streaming),   // scanner freezes the image through this
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_bit      (wr_bit)
  );

  // 480x480 one bit image
  bit_frame_buffer i_bit_frame_buffer (
    .clk_pixel (clk_pixel),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_bit    (wr_bit),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .rd_bit    (rd_bit)
  );

  // consumer, horizontal finder pass
  finder_scanner i_finder_scanner (
    .clk_pixel  (clk_pixel),
    .sys_rst    (sys_rst),
    .start      (start),
    .capture_en (streaming),
    .rd_en      (rd_en),
    .rd_addr    (rd_addr),
    .rd_bit     (rd_bit),
    .row_flags  (row_flags),
    .done       (done)
  );

endmodule

//--- tb/qr_finder_ref.svh
`ifndef QR_FINDER_REF_SVH
`define QR_FINDER_REF_SVH

// camera frame as streamed with 640 columns by 480 lines of 565 pixels
logic [15:0] img [480][640];
// bits the buffer should hold as updated only for pixels taken while streaming
bit stored_img [480][480];

// white when green times four reaches the threshold
function automatic bit binarize(input logic [15:0] p, input logic [7:0] th);
  int luma;
  luma = int'(p[10:5]) * 4;
  return luma >= int'(th);
endfunction

// outer run test 2*|4x - s| <= s
function automatic bit outer_fits(input int x, input int s);
  int d;
  d = 4 * x - s;
  if (d < 0) d = -d;
  return 2 * d <= s;
endfunction

// any five consecutive runs of stored row r starting black in the 1:1:3:1:1 shape
function automatic bit row_rule(input int r);
  int len [480];
  bit colr [480];
  int n;
  int s;
  bit hit;
  n = 0;
  hit = 0;
  for (int c = 0; c < 480; c++) begin
    if (c == 0 || stored_img[r][c] != stored_img[r][c-1]) begin // new run
      colr[n] = stored_img[r][c];
      len[n] = 0;
      n++;
    end
    len[n-1]++;
  end
  for (int i = 0; i + 4 < n; i++) begin
    s = len[i] + len[i+1] + len[i+3] + len[i+4];
    if (!colr[i] && outer_fits(len[i], s) && outer_fits(len[i+1], s) &&
        outer_fits(len[i+3], s) && outer_fits(len[i+4], s) &&
        s <= 2 * len[i+2] && len[i+2] <= s) hit = 1;
  end
  return hit;
endfunction

`endif

//--- tb/qr_finder_tb.sv
`timescale 1ns/10ps

module qr_finder_tb;
  import qr_finder_pkg::*;

  `include "qr_finder_ref.svh"

  localparam logic [15:0] white_px = 16'h07e0; // full green
  localparam logic [15:0] black_px = 16'h0000;
  localparam int frame_load = stored_width * stored_height;
  localparam int scan_len = pixel_count + 16; // reads plus pipeline
  // six scans and three window loads plus edge and partial loads and a quarter margin
  localparam int cycle_limit = (6 * scan_len + 3 * frame_load + 83200 + 33600 + 10000) * 5 / 4;

  logic clk_pixel;
  logic sys_rst;
  logic [pixel_w-1:0] pixel;
  logic [hcount_w-1:0] hcount;
  logic [vcount_w-1:0] vcount;
  logic pixel_valid;
  logic [thresh_w-1:0] thresh;
  logic start;
  logic streaming;
  logic [stored_height-1:0] row_flags;
  logic done;

  logic [stored_height-1:0] exp_flags;
  string cur_test;
  int test_err_base;
  int error_count = 0;
  int check_count = 0;
  int test_count = 0;
  int scans_checked = 0;
  int cycle_count = 0;
  bit model_capture = 1;  // mirrors capture_en in the model
  bit unknown_image = 0;  // buffer never written so only hits count

  qr_finder_top i_dut (
    .clk_pixel   (clk_pixel),
    .sys_rst     (sys_rst),
    .pixel       (pixel),
    .hcount      (hcount),
    .vcount      (vcount),
    .pixel_valid (pixel_valid),
    .thresh      (thresh),
    .start       (start),
    .streaming   (streaming),
    .row_flags   (row_flags),
    .done        (done)
  );

  initial begin
    clk_pixel = 1'b0;
    forever #2 clk_pixel = ~clk_pixel;
  end

  task automatic check_value(input string name, input logic [479:0] exp, input logic [479:0] act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("** Error %s %s: expected %0h, actual %0h", cur_test, name, exp, act);
    end
  endtask

  task automatic set_test(input string name);
    cur_test = name;
    test_err_base = error_count;
  endtask

  // one pixel per cycle with the model following the stored window
  task automatic send_pixel(input logic [15:0] p, input int h, input int v);
    @(posedge clk_pixel);
    #1;
    pixel = p;
    hcount = hcount_w'(h);
    vcount = vcount_w'(v);
    pixel_valid = 1'b1;
    if (model_capture && h < 480 && v < 480) stored_img[v][h] = binarize(p, thresh);
  endtask

  task automatic end_stream();
    @(posedge clk_pixel);
    #1 pixel_valid = 1'b0;
  endtask

  task automatic stream_image(input int r0, input int r1, input int c0, input int c1);
    for (int v = r0; v <= r1; v++) begin
      for (int h = c0; h <= c1; h++) send_pixel(img[v][h], h, v);
    end
    end_stream();
  endtask

  task automatic pulse_start();
    @(posedge clk_pixel);
    #1 start = 1'b1;
    @(posedge clk_pixel);
    #1 start = 1'b0;
  endtask

  // pixel i of a mark laid out as black u, white u, black cu, white u, black u
  function automatic logic [15:0] mark_px(input int i, input int u, input int cu);
    if (i < u || (i >= 2 * u && i < 2 * u + cu) || i >= 3 * u + cu) return black_px;
    return white_px;
  endfunction

  task automatic paint_mark(input int r, input int x0, input int u, input int cu);
    for (int i = 0; i < 4 * u + cu; i++) begin
      img[r][x0+i] = mark_px(i, u, cu);
    end
  endtask

  task automatic fill_rows(input int r0, input int r1, input logic [15:0] p);
    for (int v = r0; v <= r1; v++) begin
      for (int h = 0; h < 640; h++) img[v][h] = p;
    end
  endtask

  task automatic compute_expected();
    for (int r = 0; r < 480; r++) begin
      exp_flags[r] = row_rule(r);
    end
  endtask

  task automatic run_scan();
    int n0;
    n0 = scans_checked;
    pulse_start();
    model_capture = 0;
    while (scans_checked == n0) @(posedge clk_pixel);
  endtask

  // compare process with one pass over the flags per done strobe
  always @(posedge clk_pixel) begin
    if (!sys_rst && done === 1'b1) begin
      for (int r = 0; r < 480; r++) begin
        if (unknown_image) check_value($sformatf("row %0d", r), 0, row_flags[r] === 1'b1);
        else check_value($sformatf("row %0d", r), exp_flags[r], row_flags[r]);
      end
      test_count++;
      $display("test %s: %0d errors", cur_test, error_count - test_err_base);
      scans_checked++;
    end
  end

  always @(posedge clk_pixel) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: no done strobe after %0d cycles", cycle_count);
      $display("Done: errors found");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'h3f0e_3af9));
    sys_rst = 1'b1;
    pixel = '0;
    hcount = '0;
    vcount = '0;
    pixel_valid = 1'b0;
    thresh = 8'd128;
    start = 1'b0;
    repeat (10) @(posedge clk_pixel);
    #1 sys_rst = 1'b0;

    set_test("reset_empty_scan");
    check_value("reset streaming", 1, streaming);
    check_value("reset done", 0, done);
    check_value("reset row_flags", 0, row_flags);
    unknown_image = 1;
    run_scan();
    unknown_image = 0;

    set_test("finder_marks");
    fill_rows(0, 479, white_px);
    for (int r = 20; r < 40; r++) paint_mark(r, 50, 4, 12);
    for (int r = 100; r < 150; r++) paint_mark(r, 200, 7, 21);
    for (int r = 200; r < 220; r++) paint_mark(r, 100, 5, 5); // centre too short
    paint_mark(300, 452, 4, 12); // closes at the row end
    pulse_start();
    model_capture = 1;
    stream_image(0, 479, 0, 479);
    compute_expected();
    run_scan();

    // mostly white rows without hits so a stray write shows up as a new hit
    set_test("outside_window");
    for (int r = 0; r < 480; r++) paint_mark(r, 500, 4, 12);
    pulse_start();
    model_capture = 1;
    stream_image(0, 479, 480, 639);
    // lines so far down that the 18 bit address of 480 * vcount wraps into the window
    for (int v = 560; v < 570; v++) begin
      for (int h = 0; h < 640; h++) begin
        send_pixel((h >= 100 && h < 128) ? mark_px(h - 100, 4, 12) : white_px, h, v);
      end
    end
    end_stream();
    run_scan();

    for (int v = 0; v < 480; v++) begin
      for (int h = 0; h < 640; h++) img[v][h] = 16'($urandom);
    end
    for (int k = 0; k < 2; k++) begin
      set_test(k == 0 ? "random_thresh_100" : "random_thresh_180");
      thresh = (k == 0) ? 8'd100 : 8'd180;
      pulse_start();
      model_capture = 1;
      stream_image(0, 479, 0, 479);
      compute_expected();
      run_scan();
    end

    set_test("finished_and_restart");
    check_value("finished streaming", 0, streaming);
    fill_rows(300, 309, black_px); // rows without hits
    for (int r = 300; r < 310; r++) paint_mark(r, 60, 4, 12);
    stream_image(300, 309, 0, 479); // dropped while the design is finished
    pulse_start();
    model_capture = 1;
    check_value("restart streaming", 1, streaming);
    fill_rows(0, 29, white_px);
    fill_rows(30, 59, black_px);
    for (int r = 0; r < 30; r++) paint_mark(r, 10, 6, 18);
    stream_image(0, 59, 0, 479);
    compute_expected();
    fork
      run_scan();
      begin
        repeat (1000) @(posedge clk_pixel);
        pulse_start(); // ignored while scanning
      end
    join

    $display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- qr_finder.f
+incdir+tb
source/qr_finder_pkg.sv
source/pixel_binarizer.sv
source/bit_frame_buffer.sv
source/run_ratio_checker.sv
source/finder_scanner.sv
source/qr_finder_top.sv
tb/qr_finder_tb.sv

//--- Bender.yml
package:
  name: qr_finder

sources:
  - files:
      - source/qr_finder_pkg.sv
      - source/pixel_binarizer.sv
      - source/bit_frame_buffer.sv
      - source/run_ratio_checker.sv
      - source/finder_scanner.sv
      - source/qr_finder_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/qr_finder_tb.sv
